/* Makefile */
# Verilator build and run of the Sv39 TLB testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       := tlbTb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := *** TEST PASSED ***

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the output is printed and then searched for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+verilog
verilog/tlbPkg.sv
verilog/tlbCam.sv
verilog/tlbRam.sv
verilog/tlbReplacement.sv
verilog/tlbMixer.sv
verilog/tlb.sv
verification/tlbTb.sv

/* verification/tlbTb.sv */
// testbench for the Sv39 TLB top level
// a table of write, flush and lookup steps is built at time zero and applied in a loop
// expected lookups come from a small model of the entries and the victim pointer

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlbTb;

  localparam int MAX_STEPS    = 80;
  localparam int RESET_CYCLES = 3;
  localparam int CLK_PERIOD   = 8;

  // step operations
  localparam logic [1:0] OP_LOOKUP     = 2'd0;
  localparam logic [1:0] OP_WRITE      = 2'd1;
  localparam logic [1:0] OP_FLUSH      = 2'd2;
  localparam logic [1:0] OP_FLUSHWRITE = 2'd3;

  logic                  clk;
  logic                  reset;
  logic                  TranslationOn;
  logic [`VA_BITS-1:0]   VAdr;
  logic                  TLBWrite;
  tlbPkg::ppnT           WritePPN;
  tlbPkg::pageTypeT      WritePageType;
  logic                  TLBFlush;
  tlbPkg::paT            PAdr;
  logic                  TLBHit;
  logic                  TLBMiss;

  // stimulus table
  logic [1:0]            opTable   [MAX_STEPS];
  logic [`VA_BITS-1:0]   vadrTable [MAX_STEPS];
  logic                  onTable   [MAX_STEPS];
  tlbPkg::ppnT           ppnTable  [MAX_STEPS];
  tlbPkg::pageTypeT      typeTable [MAX_STEPS];
  string                 noteTable [MAX_STEPS];
  int                    numSteps;
  logic                  tableReady;

  // reference model state
  logic                  modelValid [`TLB_ENTRIES];
  tlbPkg::vpnT           modelVpn   [`TLB_ENTRIES];
  tlbPkg::ppnT           modelPpn   [`TLB_ENTRIES];
  tlbPkg::pageTypeT      modelType  [`TLB_ENTRIES];
  int                    modelPtr;

  int                    stepErrors;
  int                    passCount;
  int                    failCount;
  int                    seedValue;

  tlb UUT (
    .clk, .reset, .TranslationOn, .VAdr, .TLBWrite, .WritePPN, .WritePageType,
    .TLBFlush, .PAdr, .TLBHit, .TLBMiss
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // low ones for the VPN bits that a page type leaves untranslated
  function automatic tlbPkg::vpnT untranslatedMask(input tlbPkg::pageTypeT pageType);
    return tlbPkg::vpnT'((64'd1 << (`VPN_SEG_BITS * int'(pageType))) - 64'd1);
  endfunction

  // a page table leaves the low PPN bits of a superpage clear
  function automatic tlbPkg::ppnT randomPPN(input tlbPkg::pageTypeT pageType);
    tlbPkg::ppnT raw;
    raw = tlbPkg::ppnT'({$urandom, $urandom});
    return raw & ~tlbPkg::ppnT'(untranslatedMask(pageType));
  endfunction

  function automatic logic [`VA_BITS-1:0] makeVAdr(input int seg2, input int seg1,
                                                   input int seg0);
    logic [11:0] offset;
    offset = 12'($urandom);
    return {9'(seg2), 9'(seg1), 9'(seg0), offset};
  endfunction

  task automatic addStep(input logic [1:0] op, input logic [`VA_BITS-1:0] vadr,
                         input logic on, input tlbPkg::pageTypeT pageType,
                         input string note);
    opTable[numSteps]   = op;
    vadrTable[numSteps] = vadr;
    onTable[numSteps]   = on;
    ppnTable[numSteps]  = randomPPN(pageType);
    typeTable[numSteps] = pageType;
    noteTable[numSteps] = note;
    numSteps++;
  endtask

  task automatic compareValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, expected,
               actual);
      stepErrors++;
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  task automatic modelFlush();
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      modelValid[i] = 1'b0;
    end
    modelPtr = 0;
  endtask

  // lowest invalid entry first, otherwise the victim pointer, which then steps
  task automatic modelWrite(input tlbPkg::vpnT vpn, input tlbPkg::ppnT ppn,
                            input tlbPkg::pageTypeT pageType);
    int slot;
    slot = -1;
    for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!modelValid[i]) slot = i;
    end
    if (slot < 0) begin
      slot = modelPtr;
      modelPtr = (modelPtr + 1) % `TLB_ENTRIES;
    end
    modelValid[slot] = 1'b1;
    modelVpn[slot]   = vpn;
    modelPpn[slot]   = ppn;
    modelType[slot]  = pageType;
  endtask

  task automatic modelLookup(input logic [`VA_BITS-1:0] vadr, input logic on,
                             output logic hit, output tlbPkg::paT pAdr,
                             output logic miss);
    tlbPkg::vpnT vpn;
    tlbPkg::vpnT lowMask;
    tlbPkg::ppnT ppn;
    int          found;
    vpn   = vadr[`VA_BITS-1:12];
    found = -1;
    // segments above the untranslated ones must agree
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      lowMask = untranslatedMask(modelType[i]);
      if (modelValid[i] && (((modelVpn[i] ^ vpn) & ~lowMask) == '0)) found = i;
    end
    hit  = (found >= 0);
    miss = on && !hit;
    if (!on) begin
      pAdr = tlbPkg::paT'(vadr);
    end else if (hit) begin
      lowMask = untranslatedMask(modelType[found]);
      ppn  = modelPpn[found] | tlbPkg::ppnT'(vpn & lowMask);
      pAdr = {ppn, vadr[11:0]};
    end else begin
      pAdr = '0;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic buildTable();
    numSteps = 0;
    addStep(OP_LOOKUP, makeVAdr(1, 2, 3), 1'b1, tlbPkg::kiloPage, "empty after reset");
    // kilopages live under segment 2 value 1
    for (int i = 0; i < 4; i++) begin
      addStep(OP_WRITE, makeVAdr(1, 10 + i, 20 + i), 1'b1, tlbPkg::kiloPage, "write kilo");
    end
    for (int i = 0; i < 4; i++) begin
      addStep(OP_LOOKUP, makeVAdr(1, 10 + i, 20 + i), 1'b1, tlbPkg::kiloPage, "kilo hit");
    end
    addStep(OP_WRITE, makeVAdr(2, 5, 0), 1'b1, tlbPkg::megaPage, "write mega");
    addStep(OP_WRITE, makeVAdr(3, 0, 0), 1'b1, tlbPkg::gigaPage, "write giga");
    for (int i = 0; i < 2; i++) begin
      addStep(OP_LOOKUP, makeVAdr(2, 5, $urandom % 512), 1'b1, tlbPkg::kiloPage,
              "mega mixed");
      addStep(OP_LOOKUP, makeVAdr(3, $urandom % 512, $urandom % 512), 1'b1,
              tlbPkg::kiloPage, "giga mixed");
    end
    addStep(OP_LOOKUP, makeVAdr(4, 10, 20), 1'b1, tlbPkg::kiloPage, "unmapped miss");
    addStep(OP_LOOKUP, makeVAdr(2, 6, 0), 1'b1, tlbPkg::kiloPage, "mega neighbor miss");
    addStep(OP_LOOKUP, makeVAdr(1, 10, 20), 1'b0, tlbPkg::kiloPage, "bare, mapped");
    addStep(OP_LOOKUP, makeVAdr(4, 1, 1), 1'b0, tlbPkg::kiloPage, "bare, unmapped");
    // a terapage matches every address, so it gets the TLB to itself
    addStep(OP_FLUSH, '0, 1'b1, tlbPkg::kiloPage, "flush");
    addStep(OP_WRITE, makeVAdr(7, 7, 7), 1'b1, tlbPkg::teraPage, "write tera");
    for (int i = 0; i < 2; i++) begin
      addStep(OP_LOOKUP, makeVAdr($urandom % 512, $urandom % 512, $urandom % 512), 1'b1,
              tlbPkg::kiloPage, "tera mixed");
    end
    addStep(OP_LOOKUP, makeVAdr(9, 9, 9), 1'b0, tlbPkg::kiloPage, "bare over tera");
    addStep(OP_FLUSH, '0, 1'b1, tlbPkg::kiloPage, "flush");
    // ten writes fill all eight entries, then replace entries 0 and 1
    for (int i = 0; i < 10; i++) begin
      addStep(OP_WRITE, makeVAdr(6, 0, i), 1'b1, tlbPkg::kiloPage, "write fill");
    end
    for (int i = 0; i < 10; i++) begin
      addStep(OP_LOOKUP, makeVAdr(6, 0, i), 1'b1, tlbPkg::kiloPage, "after replace");
    end
    addStep(OP_FLUSH, '0, 1'b1, tlbPkg::kiloPage, "flush");
    addStep(OP_LOOKUP, makeVAdr(6, 0, 2), 1'b1, tlbPkg::kiloPage, "flushed miss");
    addStep(OP_LOOKUP, makeVAdr(6, 0, 9), 1'b1, tlbPkg::kiloPage, "flushed miss");
    addStep(OP_WRITE, makeVAdr(8, 1, 2), 1'b1, tlbPkg::kiloPage, "write after flush");
    addStep(OP_LOOKUP, makeVAdr(8, 1, 2), 1'b1, tlbPkg::kiloPage, "hit after flush");
    // the flush put the victim pointer back at 0, so the eighth refill write
    // replaces the page written just after the flush
    for (int i = 0; i < 8; i++) begin
      addStep(OP_WRITE, makeVAdr(8, 2, i), 1'b1, tlbPkg::kiloPage, "write refill");
    end
    addStep(OP_LOOKUP, makeVAdr(8, 1, 2), 1'b1, tlbPkg::kiloPage, "victim after flush");
    addStep(OP_LOOKUP, makeVAdr(8, 2, 1), 1'b1, tlbPkg::kiloPage, "refill kept");
    addStep(OP_LOOKUP, makeVAdr(8, 2, 7), 1'b1, tlbPkg::kiloPage, "refill newest");
    // flush and write together, the flush wins
    addStep(OP_FLUSHWRITE, makeVAdr(5, 4, 3), 1'b1, tlbPkg::kiloPage, "flush with write");
    addStep(OP_LOOKUP, makeVAdr(5, 4, 3), 1'b1, tlbPkg::kiloPage, "write dropped");
    addStep(OP_LOOKUP, makeVAdr(8, 2, 7), 1'b1, tlbPkg::kiloPage, "flushed miss");
  endtask

  //////////////////////////////////////////////////
  // run
  //////////////////////////////////////////////////

  initial begin
    logic       expHit;
    logic       expMiss;
    tlbPkg::paT expPAdr;
    clk           = 1'b0;
    reset         = 1'b1;
    TranslationOn = 1'b0;
    VAdr          = '0;
    TLBWrite      = 1'b0;
    WritePPN      = '0;
    WritePageType = tlbPkg::kiloPage;
    TLBFlush      = 1'b0;
    passCount     = 0;
    failCount     = 0;
    tableReady    = 1'b0;
    seedValue     = $urandom(32'h2c8f0ffa);
    buildTable();
    modelFlush();
    tableReady = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;

    for (int s = 0; s < numSteps; s++) begin
      @(posedge clk);
      #1;
      VAdr          = vadrTable[s];
      TranslationOn = onTable[s];
      WritePPN      = ppnTable[s];
      WritePageType = typeTable[s];
      TLBWrite      = (opTable[s] == OP_WRITE) || (opTable[s] == OP_FLUSHWRITE);
      TLBFlush      = (opTable[s] == OP_FLUSH) || (opTable[s] == OP_FLUSHWRITE);
      // outputs are combinational, so sample just before the next edge
      #(CLK_PERIOD - 2);
      if (opTable[s] == OP_LOOKUP) begin
        stepErrors = 0;
        modelLookup(vadrTable[s], onTable[s], expHit, expPAdr, expMiss);
        compareValue("PAdr", 64'(expPAdr), 64'(PAdr));
        compareValue("TLBHit", 64'(expHit), 64'(TLBHit));
        compareValue("TLBMiss", 64'(expMiss), 64'(TLBMiss));
        if (stepErrors == 0) begin
          passCount++;
          $display("step %0d lookup %s: ok", s, noteTable[s]);
        end else begin
          failCount++;
          $display("step %0d lookup %s: FAILED with %0d errors", s, noteTable[s],
                   stepErrors);
        end
      end else begin
        // the model follows the DUT, where the update lands on the next edge
        if (opTable[s] == OP_WRITE) begin
          modelWrite(vadrTable[s][`VA_BITS-1:12], ppnTable[s], typeTable[s]);
        end else begin
          modelFlush();
        end
        $display("step %0d %s: done", s, noteTable[s]);
      end
    end

    @(posedge clk);
    #1;
    TLBWrite = 1'b0;
    TLBFlush = 1'b0;
    $display("lookups passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog sized from the table length plus reset and a margin
  initial begin
    int timeoutNs;
    wait (tableReady);
    timeoutNs = (numSteps + RESET_CYCLES + 20) * CLK_PERIOD;
    #(timeoutNs);
    $display("ERROR: the run timed out after %0d ns without finishing the table", timeoutNs);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/tlb.sv */
// top level of the fully associative Sv39 TLB
// lookup is combinational, writes and flushes land on the next clock edge
// with translation off the virtual address goes out untouched

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlb (
  input  logic                clk,
  input  logic                reset,
  input  logic                TranslationOn,
  input  logic [`VA_BITS-1:0] VAdr,
  input  logic                TLBWrite,
  input  tlbPkg::ppnT         WritePPN,
  input  tlbPkg::pageTypeT    WritePageType,
  input  logic                TLBFlush,
  output tlbPkg::paT          PAdr,
  output logic                TLBHit,
  output logic                TLBMiss
);

  tlbPkg::vpnT              VPN;
  logic [11:0]              Offset;
  logic [`TLB_ENTRIES-1:0]  Valid;
  logic [`TLB_ENTRIES-1:0]  Matches;
  logic [`TLB_ENTRIES-1:0]  WriteEntry;
  tlbPkg::pageTypeT         HitPageType;
  tlbPkg::ppnT              HitPPN;
  tlbPkg::paT               TLBPAdr;
  logic                     CamHit;

  // the VPN being written is taken from the lookup address in the same cycle
  assign VPN    = VAdr[`VA_BITS-1:12];
  assign Offset = VAdr[11:0];

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  tlbCam cam (
    .clk, .reset, .VPN, .TLBWrite, .TLBFlush, .WriteEntry, .WritePageType,
    .Valid, .Matches, .HitPageType, .CamHit
  );

  tlbRam ram (
    .clk, .TLBWrite, .WriteEntry, .WritePPN, .Matches, .HitPPN
  );

  tlbReplacement replacement (
    .clk, .reset, .TLBWrite, .TLBFlush, .Valid, .WriteEntry
  );

  tlbMixer mixer (
    .VPN, .PPN(HitPPN), .HitPageType, .Offset, .TLBHit(CamHit), .TLBPAdr
  );

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // bare mode zero extends the 39-bit virtual address to 56 bits
  assign PAdr = TranslationOn ? TLBPAdr : tlbPkg::paT'(VAdr);

  // TLBHit reports the CAM in either mode
  // a miss only counts when the address actually needs translating
  assign TLBHit  = CamHit;
  assign TLBMiss = TranslationOn && !CamHit;

endmodule

`default_nettype wire

/* verilog/tlbCam.sv */
// content addressable half of the TLB
// holds valid bits, VPNs and page types and matches a VPN against every entry
// Matches is one-hot since software never maps one address twice

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlbCam (
  input  logic                     clk,
  input  logic                     reset,
  input  tlbPkg::vpnT              VPN,
  input  logic                     TLBWrite,
  input  logic                     TLBFlush,
  input  logic [`TLB_ENTRIES-1:0]  WriteEntry,
  input  tlbPkg::pageTypeT         WritePageType,
  output logic [`TLB_ENTRIES-1:0]  Valid,
  output logic [`TLB_ENTRIES-1:0]  Matches,
  output tlbPkg::pageTypeT         HitPageType,
  output logic                     CamHit
);

  // three segments for Sv39
  localparam int SEGMENTS = `VPN_BITS / `VPN_SEG_BITS;

  tlbPkg::vpnT      StoredVPN  [`TLB_ENTRIES-1:0];
  tlbPkg::pageTypeT StoredType [`TLB_ENTRIES-1:0];
  logic [1:0]       HitTypeBits;

  //////////////////////////////////////////////////
  // entry state
  //////////////////////////////////////////////////

  // a flush in the same cycle as a write wins, so nothing gets marked valid
  always_ff @(posedge clk) begin
    if (reset || TLBFlush) begin
      Valid <= '0;
    end else if (TLBWrite) begin
      Valid <= Valid | WriteEntry;
    end
  end

  // tag and page type only matter once the valid bit is set
  always_ff @(posedge clk) begin
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (TLBWrite && !TLBFlush && WriteEntry[i]) begin
        StoredVPN[i]  <= VPN;
        StoredType[i] <= WritePageType;
      end
    end
  end

  //////////////////////////////////////////////////
  // match
  //////////////////////////////////////////////////

  // segment s is compared only when it lies above the untranslated ones,
  // so a megapage skips segment 0 and a gigapage skips segments 0 and 1
  always_comb begin
    logic EntryMatch;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      EntryMatch = Valid[i];
      for (int s = 0; s < SEGMENTS; s++) begin
        if (s >= int'(StoredType[i])) begin
          EntryMatch = EntryMatch &&
            (StoredVPN[i][s*`VPN_SEG_BITS +: `VPN_SEG_BITS] ==
             VPN[s*`VPN_SEG_BITS +: `VPN_SEG_BITS]);
        end
      end
      Matches[i] = EntryMatch;
    end
  end

  assign CamHit = |Matches;

  // one-hot OR select of the hit entry's page type
  // with no hit every term is zero and the type reads as kilopage
  always_comb begin
    HitTypeBits = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      HitTypeBits = HitTypeBits | ({2{Matches[i]}} & StoredType[i]);
    end
  end

  assign HitPageType = tlbPkg::pageTypeT'(HitTypeBits);

endmodule

`default_nettype wire

/* verilog/tlbConfig_defs.svh */
// address format and sizing for the Sv39 TLB
// include this wherever a width or the entry count is needed
// the guard makes repeated includes in one compilation unit harmless

`ifndef TLB_CONFIG_DEFS_SVH
`define TLB_CONFIG_DEFS_SVH

//////////////////////////////////////////////////
// address widths
//////////////////////////////////////////////////

// Sv39 virtual address and the 56-bit physical address space
`define VA_BITS 39
`define PA_BITS 56

// page numbers drop the 12-bit page offset
`define VPN_BITS 27
`define PPN_BITS 44

// the VPN is three segments, one per page table level
`define VPN_SEG_BITS 9

//////////////////////////////////////////////////
// TLB sizing
//////////////////////////////////////////////////

// fully associative, so the entry count is also the CAM depth
`define TLB_ENTRIES 8
`define TLB_IDX_BITS 3

`endif

/* verilog/tlbMixer.sv */
// forms the translated physical address from a TLB hit
// superpages keep the low VPN segments, so those bits are ORed into the PPN
// the page offset is appended here and a miss forces the address to zero

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlbMixer (
  input  tlbPkg::vpnT       VPN,
  input  tlbPkg::ppnT       PPN,
  input  tlbPkg::pageTypeT  HitPageType,
  input  logic [11:0]       Offset,
  input  logic              TLBHit,
  output tlbPkg::paT        TLBPAdr
);

  logic [`PPN_BITS-1:0] ZeroExtendedVPN;
  logic [`PPN_BITS-1:0] PageNumberMask;
  logic [`PPN_BITS-1:0] PPNMixed;

  //////////////////////////////////////////////////
  // untranslated segment mask
  //////////////////////////////////////////////////

  // ones mark VPN bits that pass through to the physical page number
  always_comb begin
    case (HitPageType)
      tlbPkg::megaPage: PageNumberMask = `PPN_BITS'({`VPN_SEG_BITS{1'b1}});
      tlbPkg::gigaPage: PageNumberMask = `PPN_BITS'({(2*`VPN_SEG_BITS){1'b1}});
      tlbPkg::teraPage: PageNumberMask = `PPN_BITS'({(3*`VPN_SEG_BITS){1'b1}});
      default:          PageNumberMask = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // merge
  //////////////////////////////////////////////////

  // the page table walker leaves the low PPN bits of a superpage at zero,
  // so an OR is enough to drop the VPN segments in
  assign ZeroExtendedVPN = `PPN_BITS'(VPN);
  assign PPNMixed        = PPN | (ZeroExtendedVPN & PageNumberMask);

  // zero on a miss so a stray access can't reach a real page
  assign TLBPAdr = TLBHit ? {PPNMixed, Offset} : '0;

endmodule

`default_nettype wire

/* verilog/tlbPkg.sv */
// shared types for the TLB blocks
// refer to these as tlbPkg::name from the RTL and the testbench
// the page type value is the number of low VPN segments left untranslated

`default_nettype none

`include "tlbConfig_defs.svh"

package tlbPkg;

  //////////////////////////////////////////////////
  // page type
  //////////////////////////////////////////////////

  // a kilopage translates every segment, a terapage none of them
  typedef enum logic [1:0] {
    kiloPage = 2'd0,
    megaPage = 2'd1,
    gigaPage = 2'd2,
    teraPage = 2'd3
  } pageTypeT;

  //////////////////////////////////////////////////
  // page numbers and addresses
  //////////////////////////////////////////////////

  // virtual page number, bits 38:12 of the virtual address
  typedef logic [`VPN_BITS-1:0] vpnT;

  // physical page number as stored in the RAM
  typedef logic [`PPN_BITS-1:0] ppnT;

  // full physical address, PPN joined with the page offset
  typedef logic [`PA_BITS-1:0] paT;

endpackage

`default_nettype wire

/* verilog/tlbRam.sv */
// physical page number storage of the TLB
// written at the one-hot WriteEntry, read by the one-hot CAM match vector
// the read is an AND-OR tree, not a mux, since at most one match is set

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlbRam (
  input  logic                     clk,
  input  logic                     TLBWrite,
  input  logic [`TLB_ENTRIES-1:0]  WriteEntry,
  input  tlbPkg::ppnT              WritePPN,
  input  logic [`TLB_ENTRIES-1:0]  Matches,
  output tlbPkg::ppnT              HitPPN
);

  tlbPkg::ppnT StoredPPN [`TLB_ENTRIES-1:0];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  // a write that loses to a flush still lands here, which is harmless
  // because the CAM keeps that entry invalid
  always_ff @(posedge clk) begin
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (TLBWrite && WriteEntry[i]) begin
        StoredPPN[i] <= WritePPN;
      end
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////

  // each entry is gated by its match bit and the results ORed together
  // no match gives an all zero PPN
  always_comb begin
    HitPPN = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      HitPPN = HitPPN | ({`PPN_BITS{Matches[i]}} & StoredPPN[i]);
    end
  end

endmodule

`default_nettype wire

/* verilog/tlbReplacement.sv */
// picks the entry that the next TLB write goes to
// empty entries fill from the bottom, a full TLB is replaced round robin
// the result is one-hot to drive the CAM and RAM write enables directly

`timescale 1ns/1ps
`default_nettype none

`include "tlbConfig_defs.svh"

module tlbReplacement (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     TLBWrite,
  input  logic                     TLBFlush,
  input  logic [`TLB_ENTRIES-1:0]  Valid,
  output logic [`TLB_ENTRIES-1:0]  WriteEntry
);

  logic [`TLB_ENTRIES-1:0]  Invalid;
  logic [`TLB_ENTRIES-1:0]  FirstInvalid;
  logic [`TLB_IDX_BITS-1:0] VictimPtr;
  logic                     Full;

  // isolate the lowest set bit of the invalid vector (x AND two's complement of x)
  assign Invalid      = ~Valid;
  assign FirstInvalid = Invalid & (~Invalid + `TLB_ENTRIES'(1));
  assign Full         = &Valid;

  // victim pointer only matters once every entry holds a mapping
  assign WriteEntry = Full ? (`TLB_ENTRIES'(1) << VictimPtr) : FirstInvalid;

  //////////////////////////////////////////////////
  // round robin pointer
  //////////////////////////////////////////////////

  // it steps only on writes into a full TLB and wraps at the entry count
  // flush restarts it at entry 0 and blocks a write in the same cycle
  always_ff @(posedge clk) begin
    if (reset || TLBFlush) begin
      VictimPtr <= '0;
    end else if (TLBWrite && Full) begin
      VictimPtr <= VictimPtr + `TLB_IDX_BITS'(1);
    end
  end

endmodule

`default_nettype wire
